// ==== hdl/video_scaler_defs.svh ====
`ifndef VIDEO_SCALER_DEFS_SVH
`define VIDEO_SCALER_DEFS_SVH

// source frame, kept small for short simulations
`define VS_SRC_W        16
`define VS_SRC_H        12
`define VS_FRAC_BITS    8       // fraction bits of a scale step

// display raster, horizontal part in pixels
`define VS_H_SYNC       2
`define VS_H_BACK       3
`define VS_H_DISP       16
`define VS_H_FRONT      3

// display raster, vertical part in lines
`define VS_V_SYNC       1
`define VS_V_BACK       2
`define VS_V_DISP       12
`define VS_V_FRONT      1

`define VS_FIFO_DEPTH   32

`endif

// ==== hdl/video_scaler_pkg.sv ====
`default_nettype none

`include "video_scaler_defs.svh"

package video_scaler_pkg;

    typedef struct packed
    {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed
    {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef logic [4:0] coord_t;                    // holds 0..31

    // 5 integer bits, the rest fraction
    typedef logic [4+`VS_FRAC_BITS:0] step_t;

endpackage

`default_nettype wire

// ==== hdl/rgb565_unpack.sv ====
`default_nettype none

module rgb565_unpack
    import video_scaler_pkg::*;
(
    input  wire logic    hdmi_tx_pix_clk,
    input  wire logic    i_arst_n,
    input  wire logic    i_valid,
    input  wire logic    i_sof,
    input  wire rgb565_t i_data,
    output logic         o_ready,
    output logic         o_valid,
    output logic         o_sof,
    output pixel_t       o_pixel,
    input  wire logic    i_ready
);

    logic ready_en;

    // keeps ready low through reset and its release cycle
    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            ready_en <= 1'b0;
        else
            ready_en <= 1'b1;
    end

    assign o_ready = ready_en && (!o_valid || i_ready);   // empty or draining now

    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_valid <= 1'b0;
        else if (o_ready)
            o_valid <= i_valid;
    end

    // widen by replicating the top bits into the low bits
    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (i_valid && o_ready)
        begin
            o_sof     <= i_sof;
            o_pixel.r <= {i_data.r, i_data.r[4:2]};
            o_pixel.g <= {i_data.g, i_data.g[5:4]};
            o_pixel.b <= {i_data.b, i_data.b[4:2]};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scale_step_divider.sv ====
`default_nettype none

module scale_step_divider
    import video_scaler_pkg::*;
(
    input  wire logic   hdmi_tx_pix_clk,
    input  wire logic   i_arst_n,
    input  wire logic   i_start,
    input  wire step_t  i_dividend,
    input  wire coord_t i_divisor,
    output logic        o_done,
    output step_t       o_quotient
);

    localparam int QW = $bits(step_t);
    localparam int RW = $bits(coord_t) + 1;          // one spare bit for the trial shift

    logic                    busy;
    logic [$clog2(QW)-1:0]   cnt;                    // iterations still to go
    logic [RW-1:0]           rem_q;
    logic [RW-1:0]           rem_in;
    logic [RW-1:0]           rem_sh;
    logic [RW-1:0]           rem_nx;
    step_t                   quo_in;
    step_t                   quo_nx;
    coord_t                  div_q;
    coord_t                  div_in;
    logic                    fits;

    // one restoring step, the start cycle already does the first bit
    always_comb
    begin
        rem_in = i_start ? '0 : rem_q;
        quo_in = i_start ? i_dividend : o_quotient;
        div_in = i_start ? i_divisor : div_q;
        rem_sh = {rem_in[RW-2:0], quo_in[QW-1]};
        fits   = rem_sh >= {1'b0, div_in};
        rem_nx = fits ? rem_sh - {1'b0, div_in} : rem_sh;
        quo_nx = {quo_in[QW-2:0], fits};
    end

    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                busy <= 1'b1;
                cnt  <= ($clog2(QW))'(QW - 1);
            end
            else if (busy)
            begin
                cnt <= cnt - 1'b1;
                if (cnt == 1)                         // last quotient bit
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // dividend shifts out as the quotient shifts in
    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (i_start || busy)
        begin
            rem_q      <= rem_nx;
            o_quotient <= quo_nx;
        end
        if (i_start)
            div_q <= i_divisor;
    end

endmodule

`default_nettype wire

// ==== hdl/nearest_decimator.sv ====
`default_nettype none

`include "video_scaler_defs.svh"

module nearest_decimator
    import video_scaler_pkg::*;
(
    input  wire logic   hdmi_tx_pix_clk,
    input  wire logic   i_arst_n,
    input  wire logic   i_valid,
    input  wire logic   i_sof,
    input  wire pixel_t i_pixel,
    output logic        o_ready,
    output logic        o_valid,
    output pixel_t      o_pixel,
    input  wire logic   i_ready,
    input  wire coord_t i_dst_w,
    input  wire coord_t i_dst_h,
    output coord_t      o_dst_w,
    output coord_t      o_dst_h
);

    localparam int     FB    = `VS_FRAC_BITS;
    localparam coord_t SRC_W = coord_t'(`VS_SRC_W);
    localparam coord_t SRC_H = coord_t'(`VS_SRC_H);
    localparam step_t  NUM_W = step_t'(`VS_SRC_W << `VS_FRAC_BITS);
    localparam step_t  NUM_H = step_t'(`VS_SRC_H << `VS_FRAC_BITS);

    typedef enum logic [1:0] {S_WAIT, S_DIVW, S_DIVH, S_RUN} state_t;

    state_t state;
    logic   first;                                   // frame's sof pixel not yet taken
    logic   div_start;
    logic   div_done;
    step_t  div_num;
    coord_t div_den;
    step_t  div_quo;
    step_t  step_w;
    step_t  step_h;
    step_t  acc_x;                                   // next wanted column, fixed point
    step_t  acc_y;
    coord_t col;
    coord_t row;
    coord_t kx;                                      // columns forwarded on this line
    coord_t ky;
    coord_t dst_w_c;
    coord_t dst_h_c;
    logic   new_frame;
    logic   out_free;
    logic   take;
    logic   hit_x;
    logic   hit_y;

    assign dst_w_c = (i_dst_w == '0 || i_dst_w > SRC_W) ? SRC_W : i_dst_w;
    assign dst_h_c = (i_dst_h == '0 || i_dst_h > SRC_H) ? SRC_H : i_dst_h;

    assign out_free  = !o_valid || i_ready;
    assign new_frame = i_valid && i_sof && !first;
    assign take      = (state == S_RUN) && i_valid && o_ready;
    assign hit_x     = (col == acc_x[FB +: $bits(coord_t)]) && (kx != o_dst_w);
    assign hit_y     = (row == acc_y[FB +: $bits(coord_t)]) && (ky != o_dst_h);

    always_comb
    begin
        case (state)
            S_WAIT:  o_ready = !i_sof;               // drop strays before a frame
            S_RUN:   o_ready = out_free && !new_frame;
            default: o_ready = 1'b0;                 // sof pixel held during divides
        endcase
    end

    assign div_num = (state == S_DIVW) ? NUM_W : NUM_H;
    assign div_den = (state == S_DIVW) ? o_dst_w : o_dst_h;

    scale_step_divider u_divider (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .i_arst_n        (i_arst_n),
        .i_start         (div_start),
        .i_dividend      (div_num),
        .i_divisor       (div_den),
        .o_done          (div_done),
        .o_quotient      (div_quo)
    );

    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state     <= S_WAIT;
            first     <= 1'b0;
            div_start <= 1'b0;
            o_dst_w   <= '0;
            o_dst_h   <= '0;
        end
        else
        begin
            div_start <= 1'b0;
            case (state)
                S_WAIT, S_RUN:
                begin
                    if (i_valid && i_sof && !(state == S_RUN && first))
                    begin
                        state     <= S_DIVW;
                        div_start <= 1'b1;
                        o_dst_w   <= dst_w_c;
                        o_dst_h   <= dst_h_c;
                    end
                    else if (take)
                        first <= 1'b0;
                end
                S_DIVW:
                begin
                    if (div_done)
                    begin
                        state     <= S_DIVH;
                        div_start <= 1'b1;
                    end
                end
                default:
                begin
                    if (div_done)
                    begin
                        state <= S_RUN;
                        first <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (state == S_DIVW && div_done)
            step_w <= div_quo;
        if (state == S_DIVH && div_done)
            step_h <= div_quo;
    end

    // source position against the next wanted column and row
    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            col   <= '0;
            row   <= '0;
            kx    <= '0;
            ky    <= '0;
            acc_x <= '0;
            acc_y <= '0;
        end
        else if (state == S_DIVH && div_done)
        begin
            col   <= '0;
            row   <= '0;
            kx    <= '0;
            ky    <= '0;
            acc_x <= '0;
            acc_y <= '0;
        end
        else if (take)
        begin
            if (col == SRC_W - 1'b1)                  // end of source line
            begin
                col   <= '0;
                kx    <= '0;
                acc_x <= '0;
                row   <= row + 1'b1;
                if (hit_y)
                begin
                    acc_y <= acc_y + step_h;
                    ky    <= ky + 1'b1;
                end
            end
            else
            begin
                col <= col + 1'b1;
                if (hit_x)
                begin
                    acc_x <= acc_x + step_w;
                    kx    <= kx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_valid <= 1'b0;
        else if (out_free)
            o_valid <= take && hit_x && hit_y;
    end

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (take && hit_x && hit_y)
            o_pixel <= i_pixel;
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo #(
    parameter type payload_t = logic [23:0],
    parameter int  DEPTH     = 32
) (
    input  wire logic     hdmi_tx_pix_clk,
    input  wire logic     i_arst_n,
    input  wire logic     i_valid,
    input  wire payload_t i_data,
    output logic          o_ready,
    output logic          o_valid,
    output payload_t      o_data,
    input  wire logic     i_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            wr_en;
    logic            rd_en;

    assign o_ready = count != CW'(DEPTH);            // not full
    assign o_valid = count != '0;                    // not empty
    assign o_data  = mem[rd_ptr];                    // head, no read latency
    assign wr_en   = i_valid && o_ready;
    assign rd_en   = o_valid && i_ready;

    always_ff @(posedge hdmi_tx_pix_clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_data;
    end

    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/display_timing_gen.sv ====
`default_nettype none

`include "video_scaler_defs.svh"

module display_timing_gen
    import video_scaler_pkg::*;
(
    input  wire logic   hdmi_tx_pix_clk,
    input  wire logic   i_arst_n,
    input  wire coord_t i_dst_w,
    input  wire coord_t i_dst_h,
    input  wire logic   i_valid,
    input  wire pixel_t i_pixel,
    output logic        o_ready,
    output logic        o_vs,
    output logic        o_hs,
    output logic        o_de,
    output pixel_t      o_data,
    output logic        o_underflow
);

    localparam int H_TOTAL = `VS_H_SYNC + `VS_H_BACK + `VS_H_DISP + `VS_H_FRONT;
    localparam int V_TOTAL = `VS_V_SYNC + `VS_V_BACK + `VS_V_DISP + `VS_V_FRONT;
    localparam int H_START = `VS_H_SYNC + `VS_H_BACK;
    localparam int V_START = `VS_V_SYNC + `VS_V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    logic          running;
    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          h_end;
    logic          v_end;
    logic          h_act;
    logic          v_act;
    logic          frame_start;
    logic          de;
    coord_t        x;
    coord_t        y;
    coord_t        win_w;                            // window for the current frame
    coord_t        win_h;

    assign h_end = h_cnt == HW'(H_TOTAL - 1);
    assign v_end = v_cnt == VW'(V_TOTAL - 1);
    assign h_act = h_cnt >= HW'(H_START) && h_cnt < HW'(H_START + `VS_H_DISP);
    assign v_act = v_cnt >= VW'(V_START) && v_cnt < VW'(V_START + `VS_V_DISP);
    assign x     = coord_t'(h_cnt - HW'(H_START));
    assign y     = coord_t'(v_cnt - VW'(V_START));

    // first pixel in the FIFO kicks off the raster, then each wrap
    assign frame_start = running ? (h_end && v_end) : i_valid;

    assign de      = running && h_act && v_act && (x < win_w) && (y < win_h);
    assign o_ready = de;                              // one pop per de cycle

    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            running <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
            win_w   <= '0;
            win_h   <= '0;
        end
        else
        begin
            if (i_valid)
                running <= 1'b1;                      // never stops afterwards
            if (frame_start)
            begin
                win_w <= i_dst_w;
                win_h <= i_dst_h;
            end
            if (running)
            begin
                h_cnt <= h_end ? '0 : h_cnt + 1'b1;
                if (h_end)
                    v_cnt <= v_end ? '0 : v_cnt + 1'b1;
            end
        end
    end

    // final register stage, one cycle behind the counters
    always_ff @(posedge hdmi_tx_pix_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_vs        <= 1'b0;
            o_hs        <= 1'b0;
            o_de        <= 1'b0;
            o_data      <= '0;
            o_underflow <= 1'b0;
        end
        else
        begin
            o_hs   <= running && h_cnt < HW'(`VS_H_SYNC);
            o_vs   <= running && v_cnt < VW'(`VS_V_SYNC);
            o_de   <= de;
            o_data <= (de && i_valid) ? i_pixel : '0; // starved pixel shows black
            if (de && !i_valid)
                o_underflow <= 1'b1;                  // sticky
        end
    end

endmodule

`default_nettype wire

// ==== hdl/video_scaler_top.sv ====
`default_nettype none

`include "video_scaler_defs.svh"

module video_scaler_top
    import video_scaler_pkg::*;
(
    input  wire logic    hdmi_tx_pix_clk,
    input  wire logic    i_arst_n,
    input  wire logic    i_valid,
    input  wire logic    i_sof,
    input  wire rgb565_t i_data,
    input  wire coord_t  i_dst_w,
    input  wire coord_t  i_dst_h,
    output logic         o_ready,
    output logic         o_vs,
    output logic         o_hs,
    output logic         o_de,
    output pixel_t       o_data,
    output logic         o_underflow
);

    logic   unp_valid;
    logic   unp_sof;
    pixel_t unp_pixel;
    logic   dec_ready;
    logic   dec_valid;
    pixel_t dec_pixel;
    coord_t dst_w;
    coord_t dst_h;
    logic   fifo_ready;
    logic   fifo_valid;
    pixel_t fifo_pixel;
    logic   tg_ready;

    rgb565_unpack u_unpack (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_sof           (i_sof),
        .i_data          (i_data),
        .o_ready         (o_ready),
        .o_valid         (unp_valid),
        .o_sof           (unp_sof),
        .o_pixel         (unp_pixel),
        .i_ready         (dec_ready)
    );

    nearest_decimator u_decimator (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (unp_valid),
        .i_sof           (unp_sof),
        .i_pixel         (unp_pixel),
        .o_ready         (dec_ready),
        .o_valid         (dec_valid),
        .o_pixel         (dec_pixel),
        .i_ready         (fifo_ready),
        .i_dst_w         (i_dst_w),
        .i_dst_h         (i_dst_h),
        .o_dst_w         (dst_w),
        .o_dst_h         (dst_h)
    );

    pixel_fifo #(
        .payload_t (pixel_t),
        .DEPTH     (`VS_FIFO_DEPTH)
    ) u_fifo (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (dec_valid),
        .i_data          (dec_pixel),
        .o_ready         (fifo_ready),
        .o_valid         (fifo_valid),
        .o_data          (fifo_pixel),
        .i_ready         (tg_ready)
    );

    display_timing_gen u_timing (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .i_arst_n        (i_arst_n),
        .i_dst_w         (dst_w),
        .i_dst_h         (dst_h),
        .i_valid         (fifo_valid),
        .i_pixel         (fifo_pixel),
        .o_ready         (tg_ready),
        .o_vs            (o_vs),
        .o_hs            (o_hs),
        .o_de            (o_de),
        .o_data          (o_data),
        .o_underflow     (o_underflow)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever
            #(PERIOD / 2) o_clk = ~o_clk;
    end

    // release on a falling edge, away from the rising edge
    initial
    begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_video_scaler.sv ====
`default_nettype none

`include "video_scaler_defs.svh"

module tb_video_scaler
    import video_scaler_pkg::*;
();

    localparam int NUM_FRAMES   = 5;
    localparam int SRC_W        = `VS_SRC_W;
    localparam int SRC_H        = `VS_SRC_H;
    localparam int FB           = `VS_FRAC_BITS;
    localparam int H_TOTAL      = `VS_H_SYNC + `VS_H_BACK + `VS_H_DISP + `VS_H_FRONT;
    localparam int V_TOTAL      = `VS_V_SYNC + `VS_V_BACK + `VS_V_DISP + `VS_V_FRONT;
    localparam int MIN_STALL    = 26;                // two 13-cycle divides
    localparam int WAIT_LIMIT   = 2000;

    // requested size, then the size expected after clamping
    coord_t dst_w_tab [NUM_FRAMES] = '{5'd16, 5'd8, 5'd5, 5'd1, 5'd20};
    coord_t dst_h_tab [NUM_FRAMES] = '{5'd12, 5'd6, 5'd7, 5'd1, 5'd0};
    coord_t exp_w_tab [NUM_FRAMES] = '{5'd16, 5'd8, 5'd5, 5'd1, 5'd16};
    coord_t exp_h_tab [NUM_FRAMES] = '{5'd12, 5'd6, 5'd7, 5'd1, 5'd12};

    logic        hdmi_tx_pix_clk;
    logic        arst_n;
    logic        i_valid;
    logic        i_sof;
    rgb565_t     i_data;
    coord_t      i_dst_w;
    coord_t      i_dst_h;
    logic        o_ready;
    logic        o_vs;
    logic        o_hs;
    logic        o_de;
    pixel_t      o_data;
    logic        o_underflow;

    logic [31:0] rng_state;
    rgb565_t     frame_src [SRC_W * SRC_H];
    pixel_t      exp_q [$];
    pixel_t      exp_px;
    logic        mon_en;
    logic        prev_hs;
    logic        prev_vs;
    logic        hs_seen;
    int          vs_count;                           // display frames started
    int          hs_gap;
    int          hs_in_frame;
    int          de_in_line;
    int          lines_with_de;

    tb_clock_gen u_clock_gen (
        .o_clk    (hdmi_tx_pix_clk),
        .o_arst_n (arst_n)
    );

    video_scaler_top DUT (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .i_arst_n        (arst_n),
        .i_valid         (i_valid),
        .i_sof           (i_sof),
        .i_data          (i_data),
        .i_dst_w         (i_dst_w),
        .i_dst_h         (i_dst_h),
        .o_ready         (o_ready),
        .o_vs            (o_vs),
        .o_hs            (o_hs),
        .o_de            (o_de),
        .o_data          (o_data),
        .o_underflow     (o_underflow)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // top bits of each field repeated below it
    function automatic pixel_t expand_rgb565(input rgb565_t p);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        pixel_t     q;
        r   = p.r;
        g   = p.g;
        b   = p.b;
        q.r = (r << 3) | (r >> 2);
        q.g = (g << 2) | (g >> 4);
        q.b = (b << 3) | (b >> 2);
        return q;
    endfunction

    function automatic coord_t to_count(input int n);
        return (n > 31) ? 5'd31 : coord_t'(n);       // saturate, never wrap
    endfunction

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        stop_on_error();
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp)
        begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input coord_t exp, input coord_t act);
        if (act !== exp)
        begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("o_vs", 1'b0, o_vs);
        check_flag("o_hs", 1'b0, o_hs);
        check_flag("o_de", 1'b0, o_de);
        check_flag("o_underflow", 1'b0, o_underflow);
        check_pixel("o_data", '0, o_data);
    endtask

    // new source frame and its expected decimated pixels
    task automatic make_frame(input int f);
        int step_w;
        int step_h;
        int i;
        int j;
        int k;
        for (i = 0; i < SRC_W * SRC_H; i++)
        begin
            rng_state   = xorshift32(rng_state);
            frame_src[i] = rgb565_t'(rng_state[15:0]);
        end
        step_w = (SRC_W << FB) / exp_w_tab[f];
        step_h = (SRC_H << FB) / exp_h_tab[f];
        for (j = 0; j < exp_h_tab[f]; j++)
            for (k = 0; k < exp_w_tab[f]; k++)
                exp_q.push_back(expand_rgb565(
                    frame_src[((j * step_h) >> FB) * SRC_W + ((k * step_w) >> FB)]));
    endtask

    task automatic idle_gap();
        rng_state = xorshift32(rng_state);
        if (rng_state[2:0] == 3'd0)
        begin
            @(posedge hdmi_tx_pix_clk);
            #1;
        end
    endtask

    // called one unit after a rising edge, returns at the same point
    task automatic send_pixel(input logic sof, input rgb565_t data);
        int   waited;
        logic ready;
        waited  = 0;
        i_valid = 1'b1;
        i_sof   = sof;
        i_data  = data;
        ready   = o_ready;
        while (!ready)
        begin
            @(posedge hdmi_tx_pix_clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("input stream never became ready for a pixel");
            ready = o_ready;
        end
        @(posedge hdmi_tx_pix_clk);                  // transfer edge
        #1;
        i_valid = 1'b0;
        i_sof   = 1'b0;
    endtask

    task automatic measure_step_stall(output int low);
        low = 0;
        while (!o_ready)
        begin
            low++;
            if (low > WAIT_LIMIT)
                fail_run("o_ready stayed low after a start of frame");
            @(posedge hdmi_tx_pix_clk);
            #1;
        end
    endtask

    task automatic wait_display_frames(input int n);
        int waited;
        waited = 0;
        while (vs_count < n)
        begin
            @(posedge hdmi_tx_pix_clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("display raster did not reach the expected frame");
        end
    endtask

    task automatic close_line();
        if (de_in_line != 0)
        begin
            check_count("o_de per line", exp_w_tab[vs_count - 1], to_count(de_in_line));
            lines_with_de++;
            de_in_line = 0;
        end
    endtask

    task automatic close_frame();
        if (vs_count > 0)
        begin
            check_count("o_hs per frame", coord_t'(V_TOTAL), to_count(hs_in_frame));
            check_count("o_de lines", exp_h_tab[vs_count - 1], to_count(lines_with_de));
        end
        lines_with_de = 0;
    endtask

    // display side, sampled mid-cycle
    always @(negedge hdmi_tx_pix_clk)
    begin
        if (mon_en)
        begin
            if (o_underflow)
                fail_run("FIFO underflow flagged although the input kept it fed");
            hs_gap++;
            if (o_hs && !prev_hs)
            begin
                if (hs_seen)
                    check_count("o_hs period", coord_t'(H_TOTAL), to_count(hs_gap));
                hs_seen = 1'b1;
                hs_gap  = 0;
                close_line();
                if (o_vs && !prev_vs)
                begin
                    close_frame();
                    vs_count++;
                    hs_in_frame = 0;
                end
                hs_in_frame++;
            end
            else if (o_vs && !prev_vs)
                fail_run("o_vs rose away from the start of a line");
            if (o_de)
            begin
                if (vs_count == 0 || vs_count > NUM_FRAMES || exp_q.size() == 0)
                    fail_run("display enable seen with no expected pixel left");
                exp_px = exp_q.pop_front();
                check_pixel("o_data", exp_px, o_data);
                de_in_line++;
            end
            prev_hs = o_hs;
            prev_vs = o_vs;
        end
    end

    initial
    begin : stimulus
        int f;
        int i;
        int low;
        int waited;
        i_valid       = 1'b0;
        i_sof         = 1'b0;
        i_data        = '0;
        i_dst_w       = '0;
        i_dst_h       = '0;
        rng_state     = 32'd38;
        mon_en        = 1'b0;
        prev_hs       = 1'b0;
        prev_vs       = 1'b0;
        hs_seen       = 1'b0;
        vs_count      = 0;
        hs_gap        = 0;
        hs_in_frame   = 0;
        de_in_line    = 0;
        lines_with_de = 0;
        waited        = 0;

        @(posedge hdmi_tx_pix_clk);
        #1;
        while (!arst_n)
        begin
            check_flag("o_ready", 1'b0, o_ready);
            check_idle_outputs();
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("reset was never released");
            @(posedge hdmi_tx_pix_clk);
            #1;
        end
        @(posedge hdmi_tx_pix_clk);
        #1;
        check_flag("o_ready", 1'b1, o_ready);       // up one cycle after reset
        check_idle_outputs();
        mon_en = 1'b1;

        for (f = 0; f < NUM_FRAMES; f++)
        begin
            wait_display_frames(f);                  // previous window already latched
            make_frame(f);
            i_dst_w = dst_w_tab[f];
            i_dst_h = dst_h_tab[f];
            idle_gap();
            send_pixel(1'b1, frame_src[0]);
            measure_step_stall(low);
            if (low < MIN_STALL)
                fail_run("o_ready did not stay low while the scale steps were computed");
            for (i = 1; i < SRC_W * SRC_H; i++)
            begin
                idle_gap();
                send_pixel(1'b0, frame_src[i]);
            end
        end

        wait_display_frames(NUM_FRAMES + 1);         // last frame fully shown
        if (exp_q.size() != 0 || o_underflow)
            fail_run("not every expected pixel reached the display");
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/video_scaler_pkg.sv
hdl/rgb565_unpack.sv
hdl/scale_step_divider.sv
hdl/nearest_decimator.sv
hdl/pixel_fifo.sv
hdl/display_timing_gen.sv
hdl/video_scaler_top.sv
testbench/tb_clock_gen.sv
testbench/tb_video_scaler.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_video_scaler
FILELIST = sources.f
OBJ_DIR  = obj_dir

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
